// File: build.f
+incdir+hw
+incdir+verif
hw/vbus_pkg.sv
hw/extbus_6502_if.sv
hw/line_fetch.sv
hw/vram_arbiter.sv
hw/vram.sv
hw/video_subsys_top.sv
verif/tb_video_subsys.sv

// File: Bender.yml
package:
  name: video_subsys

sources:
  - include_dirs:
      - hw
    files:
      - hw/vbus_pkg.sv
      - hw/extbus_6502_if.sv
      - hw/line_fetch.sv
      - hw/vram_arbiter.sv
      - hw/vram.sv
      - hw/video_subsys_top.sv
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/tb_video_subsys.sv

// File: verif/tb_6502_bus.svh
`ifndef TB_6502_BUS_SVH
`define TB_6502_BUS_SVH

// 6502 host bus model, included inside the testbench module.
// Works on clk, phi2 and the pad drivers bus_cs_n, bus_rw_n, bus_a,
// bus_dout and bus_drive of the including module.

// Edges to wait for one phi2 level before giving up
localparam int PHI2_WAIT_MAX = 2 ** (`EXTBUS_CLKDIV_W + 1);

// Edges from the first high sample of phi2 to one clk before it falls
localparam int READ_SAMPLE_DLY = 2 ** (`EXTBUS_CLKDIV_W - 1) - 2;

////////////////////////////////////////////////////////////
// phi2 tracking
////////////////////////////////////////////////////////////

// Returns on the first clk edge that sees phi2 at the given level
task automatic wait_phi2(input logic level, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (phi2 !== level) begin
        n++;
        if (n > PHI2_WAIT_MAX) begin
            timeout_fail(what);
        end
        @(posedge clk);
    end
endtask

// Cycles start right after phi2 falls, as on the real bus
task automatic wait_phi2_fall(input string what);
    wait_phi2(1'b1, what);
    wait_phi2(1'b0, what);
endtask

////////////////////////////////////////////////////////////
// Bus cycles
////////////////////////////////////////////////////////////

task automatic bus_write(input vbus_pkg::reg_idx_t a, input vbus_pkg::byte_t d);
    wait_phi2_fall("phi2 to fall before a write cycle");
    // Address and data set up while phi2 is low
    bus_a     <= a;
    bus_dout  <= d;
    bus_rw_n  <= 1'b0;
    bus_cs_n  <= 1'b0;
    bus_drive <= 1'b1;
    wait_phi2(1'b1, "phi2 to rise in a write cycle");
    // Held until phi2 has fallen, the slave takes the last high sample
    wait_phi2(1'b0, "phi2 to fall at the end of a write cycle");
    bus_cs_n  <= 1'b1;
    bus_rw_n  <= 1'b1;
    bus_drive <= 1'b0;
endtask

task automatic bus_read(input vbus_pkg::reg_idx_t a, output vbus_pkg::byte_t d);
    wait_phi2_fall("phi2 to fall before a read cycle");
    bus_a    <= a;
    bus_rw_n <= 1'b1;
    bus_cs_n <= 1'b0;
    wait_phi2(1'b1, "phi2 to rise in a read cycle");
    repeat (READ_SAMPLE_DLY) @(posedge clk);
    d = extbus_d;
    wait_phi2(1'b0, "phi2 to fall at the end of a read cycle");
    bus_cs_n <= 1'b1;
endtask

`endif

// File: verif/tb_video_subsys.sv
`default_nettype none

`include "vbus_defines.svh"

module tb_video_subsys;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h66ac_98f8;

    // Clock edges allowed for a status change or a whole line fetch
    localparam int WAIT_MAX = 4000;

    // Host register map
    localparam vbus_pkg::reg_idx_t REG_PTR_HI = 3'd0;
    localparam vbus_pkg::reg_idx_t REG_PTR_MD = 3'd1;
    localparam vbus_pkg::reg_idx_t REG_PTR_LO = 3'd2;
    localparam vbus_pkg::reg_idx_t REG_PORT0  = 3'd3;
    localparam vbus_pkg::reg_idx_t REG_PORT1  = 3'd4;
    localparam vbus_pkg::reg_idx_t REG_CTRL   = 3'd5;
    localparam vbus_pkg::reg_idx_t REG_IEN    = 3'd6;
    localparam vbus_pkg::reg_idx_t REG_ISR    = 3'd7;

    logic clk = 1'b0;
    logic rst;

    // Host pad drivers
    logic               bus_cs_n;
    logic               bus_rw_n;
    logic               bus_drive;
    vbus_pkg::reg_idx_t bus_a;
    vbus_pkg::byte_t    bus_dout;

    wire [7:0] extbus_d;
    wire       extbus_phi2_n;
    wire       extbus_irq_n;
    wire       phi2;

    logic [`IRQ_W-1:1]    irq_src;
    logic                 fetch_start;
    vbus_pkg::vram_addr_t fetch_base;
    vbus_pkg::byte_t      fetch_count;
    wire [7:0]            pix_data;
    wire                  pix_valid;
    wire                  fetch_done;
    wire                  warmboot_req;

    assign extbus_d = bus_drive ? bus_dout : 8'bz;
    assign phi2     = !extbus_phi2_n;

    // Open-drain IRQ line
    pullup (extbus_irq_n);

    always #2 clk = ~clk;

    video_subsys_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .extbus_phi2_n (extbus_phi2_n),
        .extbus_cs_n   (bus_cs_n),
        .extbus_rw_n   (bus_rw_n),
        .extbus_a      (bus_a),
        .extbus_d      (extbus_d),
        .extbus_irq_n  (extbus_irq_n),
        .irq_src       (irq_src),
        .fetch_start   (fetch_start),
        .fetch_base    (fetch_base),
        .fetch_count   (fetch_count),
        .pix_data      (pix_data),
        .pix_valid     (pix_valid),
        .fetch_done    (fetch_done),
        .warmboot_req  (warmboot_req)
    );

    `include "tb_6502_bus.svh"

    ////////////////////////////////////////////////////////////
    // Checking and helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic wait_irq_level(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (extbus_irq_n !== level) begin
            n++;
            if (n > WAIT_MAX) begin
                timeout_fail($sformatf("extbus_irq_n to go to %0b", level));
            end
            @(posedge clk);
        end
    endtask

    // Fill pattern for fetch data mixing every address bit
    function automatic vbus_pkg::byte_t fill_byte(input vbus_pkg::vram_addr_t a);
        return a[7:0] ^ a[15:8] ^ {5'b0, a[`VRAM_ADDR_W-1:16]} ^ 8'h96;
    endfunction

    task automatic set_pointer(input logic sel, input vbus_pkg::vram_addr_t addr,
                               input vbus_pkg::addr_incr_t incr);
        bus_write(REG_CTRL, {7'b0, sel});
        // Bit 3 written as 1 must read back as 0
        bus_write(REG_PTR_HI, {incr, 1'b1, addr[`VRAM_ADDR_W-1:16]});
        bus_write(REG_PTR_MD, addr[15:8]);
        bus_write(REG_PTR_LO, addr[7:0]);
    endtask

    task automatic check_pointer(input logic sel, input vbus_pkg::vram_addr_t addr,
                                 input vbus_pkg::addr_incr_t incr);
        vbus_pkg::byte_t d;
        bus_write(REG_CTRL, {7'b0, sel});
        bus_read(REG_PTR_HI, d);
        check($sformatf("pointer %0d reg 0", sel), d, {incr, 1'b0, addr[`VRAM_ADDR_W-1:16]});
        bus_read(REG_PTR_MD, d);
        check($sformatf("pointer %0d reg 1", sel), d, addr[15:8]);
        bus_read(REG_PTR_LO, d);
        check($sformatf("pointer %0d reg 2", sel), d, addr[7:0]);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        vbus_pkg::byte_t d;
        int              r;
        @(posedge clk);
        check("extbus_irq_n", extbus_irq_n, 1'b1);
        check("warmboot_req", warmboot_req, 1'b0);
        check("pix_valid", pix_valid, 1'b0);
        check("fetch_done", fetch_done, 1'b0);
        // Data ports return VRAM contents that are undefined until written
        for (r = 0; r < 8; r++) begin
            if (r != REG_PORT0 && r != REG_PORT1) begin
                bus_read(vbus_pkg::reg_idx_t'(r), d);
                check($sformatf("reg %0d", r), d, 8'h00);
            end
        end
    endtask

    task automatic test_pointers();
        set_pointer(1'b0, 19'h5_A5C3, 4'h9);
        set_pointer(1'b1, 19'h2_3C7E, 4'h3);
        check_pointer(1'b1, 19'h2_3C7E, 4'h3);
        check_pointer(1'b0, 19'h5_A5C3, 4'h9);
    endtask

    task automatic test_data_ports();
        vbus_pkg::vram_addr_t start;
        vbus_pkg::vram_addr_t high;
        vbus_pkg::byte_t      data [8];
        vbus_pkg::byte_t      d;
        int                   i;
        start = 19'h0_0040;
        set_pointer(1'b0, start, 4'd1);
        for (i = 0; i < 8; i++) begin
            data[i] = vbus_pkg::byte_t'($urandom);
            bus_write(REG_PORT0, data[i]);
        end
        set_pointer(1'b1, start, 4'd1);
        for (i = 0; i < 8; i++) begin
            bus_read(REG_PORT1, d);
            check("port 4 data", d, data[i]);
        end
        check_pointer(1'b0, start + 19'd8, 4'd1);
        check_pointer(1'b1, start + 19'd8, 4'd1);

        // Increment 0 keeps rewriting one byte and leaves its neighbour
        start = 19'h0_0080;
        set_pointer(1'b0, start, 4'd1);
        bus_write(REG_PORT0, 8'h11);
        bus_write(REG_PORT0, 8'h22);
        set_pointer(1'b0, start, 4'd0);
        bus_write(REG_PORT0, 8'hC7);
        bus_write(REG_PORT0, 8'h6E);
        check_pointer(1'b0, start, 4'd0);
        set_pointer(1'b1, start, 4'd1);
        bus_read(REG_PORT1, d);
        check("port 4 data", d, 8'h6E);
        bus_read(REG_PORT1, d);
        check("port 4 data", d, 8'h22);

        // Address above the RAM depth lands on its low bits
        high = 19'h6_32A0;
        set_pointer(1'b0, high, 4'd1);
        data[0] = vbus_pkg::byte_t'($urandom);
        bus_write(REG_PORT0, data[0]);
        set_pointer(1'b1, vbus_pkg::vram_addr_t'(high[`VRAM_DEPTH_LOG2-1:0]), 4'd1);
        bus_read(REG_PORT1, d);
        check("port 4 aliased data", d, data[0]);
    endtask

    task automatic test_line_fetch();
        vbus_pkg::vram_addr_t base;
        vbus_pkg::vram_addr_t other;
        vbus_pkg::byte_t      host_data [4];
        vbus_pkg::byte_t      d;
        int                   n;
        int                   guard;
        int                   i;
        int                   j;
        base  = 19'h0_0100;
        other = 19'h0_0C00;
        set_pointer(1'b0, base, 4'd1);
        for (i = 0; i < 256; i++) begin
            bus_write(REG_PORT0, fill_byte(base + i));
        end
        set_pointer(1'b1, other, 4'd1);

        fork
            begin
                @(posedge clk);
                fetch_base  <= base;
                fetch_count <= 8'd0;   // full 256 byte line
                fetch_start <= 1'b1;
                @(posedge clk);
                fetch_start <= 1'b0;
                n     = 0;
                guard = 0;
                while (fetch_done !== 1'b1) begin
                    @(posedge clk);
                    if (pix_valid === 1'b1) begin
                        check("pix_data", pix_data, fill_byte(base + n));
                        n++;
                    end
                    guard++;
                    if (guard > WAIT_MAX) begin
                        timeout_fail("fetch_done after a 256 byte fetch");
                    end
                end
                check("pix_valid count", n, 256);
            end
            begin
                // Host traffic into VRAM while the fetch runs
                for (j = 0; j < 4; j++) begin
                    host_data[j] = vbus_pkg::byte_t'($urandom);
                    bus_write(REG_PORT1, host_data[j]);
                end
            end
        join

        set_pointer(1'b1, other, 4'd1);
        for (j = 0; j < 4; j++) begin
            bus_read(REG_PORT1, d);
            check("port 4 data", d, host_data[j]);
        end
    endtask

    task automatic test_interrupts();
        vbus_pkg::byte_t d;
        // Source 0 is already set by the finished fetch
        bus_read(REG_ISR, d);
        check("ISR", d, 8'h01);
        check("extbus_irq_n", extbus_irq_n, 1'b1);
        @(posedge clk);
        irq_src[3] <= 1'b1;
        @(posedge clk);
        irq_src[3] <= 1'b0;
        bus_read(REG_ISR, d);
        check("ISR", d, 8'h09);

        // Enabled source not pending so the line stays released
        bus_write(REG_IEN, 8'h02);
        bus_read(REG_IEN, d);
        check("IEN", d, 8'h02);
        check("extbus_irq_n", extbus_irq_n, 1'b1);

        bus_write(REG_IEN, 8'h0A);
        wait_irq_level(1'b0);
        bus_write(REG_ISR, 8'h08);
        wait_irq_level(1'b1);
        bus_read(REG_ISR, d);
        check("ISR", d, 8'h01);

        bus_write(REG_IEN, 8'h01);
        wait_irq_level(1'b0);
        bus_write(REG_ISR, 8'h01);
        wait_irq_level(1'b1);
        bus_read(REG_ISR, d);
        check("ISR", d, 8'h00);
        bus_write(REG_IEN, 8'h00);
    endtask

    task automatic test_warmboot();
        vbus_pkg::byte_t d;
        int              n;
        bus_write(REG_CTRL, 8'h80);
        n = 0;
        @(posedge clk);
        while (warmboot_req !== 1'b1) begin
            n++;
            if (n > WAIT_MAX) begin
                timeout_fail("warmboot_req to rise");
            end
            @(posedge clk);
        end
        bus_read(REG_CTRL, d);
        check("reg 5", d, 8'h80);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rw_n    = 1'b1;
        bus_drive   = 1'b0;
        bus_a       = '0;
        bus_dout    = '0;
        irq_src     = '0;
        fetch_start = 1'b0;
        fetch_base  = '0;
        fetch_count = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_reset();
        test_pointers();
        test_data_ports();
        test_line_fetch();
        test_interrupts();
        test_warmboot();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/video_subsys_top.sv
`default_nettype none

`include "vbus_defines.svh"

module video_subsys_top (
    input  wire                       clk,
    input  wire                       rst,

    // 6502 pads
    output wire                       extbus_phi2_n,
    input  wire                       extbus_cs_n,
    input  wire                       extbus_rw_n,
    input  wire vbus_pkg::reg_idx_t   extbus_a,
    inout  wire vbus_pkg::byte_t      extbus_d,
    output wire                       extbus_irq_n,

    // Interrupt sources above the fetcher
    input  wire [`IRQ_W-1:1]          irq_src,

    // Line fetch control and pixel stream
    input  wire                       fetch_start,
    input  wire vbus_pkg::vram_addr_t fetch_base,
    input  wire vbus_pkg::byte_t      fetch_count,
    output wire vbus_pkg::byte_t      pix_data,
    output wire                       pix_valid,
    output wire                       fetch_done,

    output wire                       warmboot_req
);

    // CPU master
    wire vbus_pkg::vram_addr_t cpu_addr;
    wire vbus_pkg::byte_t      cpu_wrdata;
    wire vbus_pkg::byte_t      cpu_rddata;
    wire                       cpu_strobe;
    wire                       cpu_write;

    // Fetcher master
    wire                       fetch_req;
    wire vbus_pkg::vram_addr_t fetch_addr;
    wire                       fetch_gnt;
    wire                       fetch_rvalid;
    wire vbus_pkg::byte_t      fetch_rddata;

    // RAM port
    wire                       mem_en;
    wire                       mem_we;
    wire vbus_pkg::vram_addr_t mem_addr;
    wire vbus_pkg::byte_t      mem_wrdata;
    wire vbus_pkg::byte_t      mem_rddata;

    wire vbus_pkg::irq_vec_t   irqs;

    // Fetch completion is source 0
    assign irqs = {irq_src, fetch_done};

    extbus_6502_if i_extbus (
        .rst           (rst),
        .clk           (clk),
        .extbus_phi2_n (extbus_phi2_n),
        .extbus_cs_n   (extbus_cs_n),
        .extbus_rw_n   (extbus_rw_n),
        .extbus_a      (extbus_a),
        .extbus_d      (extbus_d),
        .extbus_irq_n  (extbus_irq_n),
        .cpu_addr      (cpu_addr),
        .cpu_wrdata    (cpu_wrdata),
        .cpu_rddata    (cpu_rddata),
        .cpu_strobe    (cpu_strobe),
        .cpu_write     (cpu_write),
        .irqs          (irqs),
        .warmboot_req  (warmboot_req)
    );

    line_fetch i_fetch (
        .clk          (clk),
        .rst          (rst),
        .start        (fetch_start),
        .base         (fetch_base),
        .count        (fetch_count),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_gnt    (fetch_gnt),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rddata (fetch_rddata),
        .pix_data     (pix_data),
        .pix_valid    (pix_valid),
        .done         (fetch_done)
    );

    vram_arbiter i_arb (
        .clk          (clk),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_wrdata   (cpu_wrdata),
        .cpu_rddata   (cpu_rddata),
        .cpu_strobe   (cpu_strobe),
        .cpu_write    (cpu_write),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_gnt    (fetch_gnt),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rddata (fetch_rddata),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wrdata   (mem_wrdata),
        .mem_rddata   (mem_rddata)
    );

    vram i_vram (
        .clk        (clk),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wrdata (mem_wrdata),
        .mem_rddata (mem_rddata)
    );

endmodule

`default_nettype wire

// File: hw/vram.sv
`default_nettype none

`include "vbus_defines.svh"

module vram (
    input  wire                       clk,

    input  wire                       mem_en,
    input  wire                       mem_we,
    input  wire vbus_pkg::vram_addr_t mem_addr,
    input  wire vbus_pkg::byte_t      mem_wrdata,
    output vbus_pkg::byte_t           mem_rddata
);

    localparam int DEPTH = 2 ** `VRAM_DEPTH_LOG2;

    vbus_pkg::byte_t mem [DEPTH];

    // Only the low address bits select a byte
    logic [`VRAM_DEPTH_LOG2-1:0] idx;

    assign idx = mem_addr[`VRAM_DEPTH_LOG2-1:0];

    ////////////////////////////////////////////////////////////
    // Single port, read data registered
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[idx] <= mem_wrdata;
            end else begin
                mem_rddata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vram_arbiter.sv
`default_nettype none

module vram_arbiter (
    input  wire                       clk,
    input  wire                       rst,

    // CPU master, never stalled
    input  wire vbus_pkg::vram_addr_t cpu_addr,
    input  wire vbus_pkg::byte_t      cpu_wrdata,
    output vbus_pkg::byte_t           cpu_rddata,
    input  wire                       cpu_strobe,
    input  wire                       cpu_write,

    // Line fetcher
    input  wire                       fetch_req,
    input  wire vbus_pkg::vram_addr_t fetch_addr,
    output logic                      fetch_gnt,
    output logic                      fetch_rvalid,
    output vbus_pkg::byte_t           fetch_rddata,

    // RAM port
    output logic                      mem_en,
    output logic                      mem_we,
    output vbus_pkg::vram_addr_t      mem_addr,
    output vbus_pkg::byte_t           mem_wrdata,
    input  wire vbus_pkg::byte_t      mem_rddata
);

    // Owner of the read data coming back next cycle
    logic cpu_rd_q;

    // CPU wins, fetcher gets any idle cycle
    assign fetch_gnt  = fetch_req && !cpu_strobe;

    assign mem_en     = cpu_strobe || fetch_req;
    assign mem_we     = cpu_strobe && cpu_write;
    assign mem_addr   = cpu_strobe ? cpu_addr : fetch_addr;
    assign mem_wrdata = cpu_wrdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_rd_q     <= 1'b0;
            fetch_rvalid <= 1'b0;
        end else begin
            cpu_rd_q     <= cpu_strobe && !cpu_write;
            fetch_rvalid <= fetch_gnt;
        end
    end

    assign cpu_rddata   = cpu_rd_q     ? mem_rddata : 8'h00;
    assign fetch_rddata = fetch_rvalid ? mem_rddata : 8'h00;

endmodule

`default_nettype wire

// File: hw/line_fetch.sv
`default_nettype none

module line_fetch (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     start,
    input  wire vbus_pkg::vram_addr_t base,
    input  wire vbus_pkg::byte_t    count,

    // Arbiter side
    output logic                    fetch_req,
    output vbus_pkg::vram_addr_t    fetch_addr,
    input  wire                     fetch_gnt,
    input  wire                     fetch_rvalid,
    input  wire vbus_pkg::byte_t    fetch_rddata,

    // Pixel stream
    output vbus_pkg::byte_t         pix_data,
    output logic                    pix_valid,
    output logic                    done
);

    vbus_pkg::fetch_state_t state_q;

    // Requests still to issue and bytes still to come back
    logic [8:0] req_left_q;
    logic [8:0] ret_left_q;
    logic [8:0] run_len;
    logic       last_ret;

    // Count of zero stands for a full 256 bytes
    assign run_len = {(count == 8'd0), count};

    assign fetch_req = (state_q == vbus_pkg::FETCH_RUN) && (req_left_q != 9'd0);

    assign pix_data  = fetch_rddata;
    assign pix_valid = fetch_rvalid && (state_q == vbus_pkg::FETCH_RUN);
    assign last_ret  = pix_valid && (ret_left_q == 9'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= vbus_pkg::FETCH_IDLE;
            req_left_q <= '0;
            ret_left_q <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                vbus_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state_q    <= vbus_pkg::FETCH_RUN;
                        req_left_q <= run_len;
                        ret_left_q <= run_len;
                    end
                end
                vbus_pkg::FETCH_RUN: begin
                    if (fetch_gnt) begin
                        req_left_q <= req_left_q - 1'b1;
                    end
                    if (pix_valid) begin
                        ret_left_q <= ret_left_q - 1'b1;
                    end
                    if (last_ret) begin
                        done    <= 1'b1;
                        state_q <= vbus_pkg::FETCH_IDLE;
                    end
                end
                default: state_q <= vbus_pkg::FETCH_IDLE;
            endcase
        end
    end

    // Next byte address, steps on every grant
    always_ff @(posedge clk) begin
        if (state_q == vbus_pkg::FETCH_IDLE && start) begin
            fetch_addr <= base;
        end else if (fetch_gnt) begin
            fetch_addr <= fetch_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/extbus_6502_if.sv
`default_nettype none

`include "vbus_defines.svh"

module extbus_6502_if (
    input  wire                   rst,
    input  wire                   clk,

    // 6502 slave side
    output wire                   extbus_phi2_n,
    input  wire                   extbus_cs_n,
    input  wire                   extbus_rw_n,
    input  wire vbus_pkg::reg_idx_t extbus_a,
    inout  wire vbus_pkg::byte_t  extbus_d,
    output wire                   extbus_irq_n,

    // VRAM bus master side
    output vbus_pkg::vram_addr_t  cpu_addr,
    output vbus_pkg::byte_t       cpu_wrdata,
    input  wire vbus_pkg::byte_t  cpu_rddata,
    output logic                  cpu_strobe,
    output logic                  cpu_write,

    input  wire vbus_pkg::irq_vec_t irqs,
    output wire                   warmboot_req
);

    // Host register map
    localparam vbus_pkg::reg_idx_t REG_PTR_HI = 3'd0;
    localparam vbus_pkg::reg_idx_t REG_PTR_MD = 3'd1;
    localparam vbus_pkg::reg_idx_t REG_PTR_LO = 3'd2;
    localparam vbus_pkg::reg_idx_t REG_PORT0  = 3'd3;
    localparam vbus_pkg::reg_idx_t REG_PORT1  = 3'd4;
    localparam vbus_pkg::reg_idx_t REG_CTRL   = 3'd5;
    localparam vbus_pkg::reg_idx_t REG_IEN    = 3'd6;
    localparam vbus_pkg::reg_idx_t REG_ISR    = 3'd7;

    // Two address pointers, indexed by pointer number
    vbus_pkg::vram_addr_t [1:0] ptr_addr_q, ptr_addr_d;
    vbus_pkg::addr_incr_t [1:0] ptr_incr_q, ptr_incr_d;
    logic                       sel_q, sel_d;
    vbus_pkg::irq_vec_t         ien_q, ien_d;
    vbus_pkg::irq_vec_t         isr_q, isr_d;
    logic                       warmboot_q, warmboot_d;

    // Last byte read from VRAM through a data port
    vbus_pkg::byte_t            rd_q;
    logic                       rd_pend_q;

    vbus_pkg::byte_t            rd_mux;
    logic                       irq_active;

    ////////////////////////////////////////////////////////////
    // phi2 generation
    ////////////////////////////////////////////////////////////

    logic [`EXTBUS_CLKDIV_W-1:0] clkdiv_q;
    logic                        phi2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clkdiv_q <= '0;
        end else begin
            clkdiv_q <= clkdiv_q + 1'b1;
        end
    end

    assign phi2          = clkdiv_q[`EXTBUS_CLKDIV_W-1];
    assign extbus_phi2_n = ~phi2;

    ////////////////////////////////////////////////////////////
    // Bus-side read path, combinational on the pads
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (extbus_a)
            REG_PTR_HI: rd_mux = {ptr_incr_q[sel_q], 1'b0, ptr_addr_q[sel_q][`VRAM_ADDR_W-1:16]};
            REG_PTR_MD: rd_mux = ptr_addr_q[sel_q][15:8];
            REG_PTR_LO: rd_mux = ptr_addr_q[sel_q][7:0];
            REG_PORT0,
            REG_PORT1:  rd_mux = rd_q;
            REG_CTRL:   rd_mux = {warmboot_q, 6'b0, sel_q};
            REG_IEN:    rd_mux = ien_q;
            REG_ISR:    rd_mux = isr_q;
            default:    rd_mux = 8'h00;
        endcase
    end

    assign extbus_d = (!extbus_cs_n && extbus_rw_n) ? rd_mux : 8'bz;

    // Open drain, pulled up outside
    assign irq_active   = |(isr_q & ien_q);
    assign extbus_irq_n = irq_active ? 1'b0 : 1'bz;

    assign warmboot_req = warmboot_q;

    ////////////////////////////////////////////////////////////
    // Synchronizers into clk
    ////////////////////////////////////////////////////////////

    logic [1:0] cs_sync_q;
    logic [2:0] acc_sync_q;
    logic       ext_access;
    logic       access_start;
    logic       access_end;

    // phi2 qualified by chip select
    assign ext_access = phi2 && !extbus_cs_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_sync_q  <= '0;
            acc_sync_q <= '0;
        end else begin
            cs_sync_q  <= {cs_sync_q[0], !extbus_cs_n};
            acc_sync_q <= {acc_sync_q[1:0], ext_access};
        end
    end

    assign access_start = (acc_sync_q[2:1] == 2'b01) && cs_sync_q[1];
    assign access_end   = (acc_sync_q[2:1] == 2'b10);

    // Sample address, data and direction while the access is active,
    // the write uses the sample three deep
    vbus_pkg::reg_idx_t [2:0] addr_p;
    vbus_pkg::byte_t    [2:0] wdata_p;
    logic               [2:0] rw_p;

    always_ff @(posedge clk) begin
        if (acc_sync_q[1]) begin
            addr_p  <= {addr_p[1:0], extbus_a};
            wdata_p <= {wdata_p[1:0], extbus_d};
            rw_p    <= {rw_p[1:0], extbus_rw_n};
        end
    end

    ////////////////////////////////////////////////////////////
    // Register update and bus master requests
    ////////////////////////////////////////////////////////////

    logic acc_go;
    logic acc_port;
    logic acc_write;

    always_comb begin
        ptr_addr_d = ptr_addr_q;
        ptr_incr_d = ptr_incr_q;
        sel_d      = sel_q;
        ien_d      = ien_q;
        isr_d      = isr_q;
        warmboot_d = warmboot_q;
        acc_go     = 1'b0;
        acc_port   = 1'b0;
        acc_write  = 1'b0;

        // Reads go out early so data is back within the same phi2 high
        if (access_start && extbus_rw_n &&
            (extbus_a == REG_PORT0 || extbus_a == REG_PORT1)) begin
            acc_go   = 1'b1;
            acc_port = (extbus_a == REG_PORT1);
        end

        if (access_end && !rw_p[2]) begin
            case (addr_p[2])
                REG_PTR_HI: begin
                    ptr_incr_d[sel_q]                      = wdata_p[2][7:4];
                    ptr_addr_d[sel_q][`VRAM_ADDR_W-1:16]   = wdata_p[2][2:0];
                end
                REG_PTR_MD: ptr_addr_d[sel_q][15:8] = wdata_p[2];
                REG_PTR_LO: ptr_addr_d[sel_q][7:0]  = wdata_p[2];
                REG_PORT0,
                REG_PORT1: begin
                    acc_go    = 1'b1;
                    acc_write = 1'b1;
                    acc_port  = (addr_p[2] == REG_PORT1);
                end
                REG_CTRL: begin
                    warmboot_d = wdata_p[2][7];
                    sel_d      = wdata_p[2][0];
                end
                REG_IEN:  ien_d = wdata_p[2];
                REG_ISR:  isr_d = isr_q & ~wdata_p[2];
                default: begin
                end
            endcase
        end

        // Sources keep setting status every cycle
        isr_d = isr_d | irqs;

        // Post-increment of the pointer used by this access
        if (acc_go) begin
            ptr_addr_d[acc_port] = ptr_addr_q[acc_port] +
                                   vbus_pkg::vram_addr_t'(ptr_incr_q[acc_port]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_addr_q <= '0;
            ptr_incr_q <= '0;
            sel_q      <= 1'b0;
            ien_q      <= '0;
            isr_q      <= '0;
            warmboot_q <= 1'b0;
            cpu_strobe <= 1'b0;
            cpu_write  <= 1'b0;
            rd_pend_q  <= 1'b0;
            rd_q       <= '0;
        end else begin
            ptr_addr_q <= ptr_addr_d;
            ptr_incr_q <= ptr_incr_d;
            sel_q      <= sel_d;
            ien_q      <= ien_d;
            isr_q      <= isr_d;
            warmboot_q <= warmboot_d;
            cpu_strobe <= acc_go;
            cpu_write  <= acc_write;
            rd_pend_q  <= cpu_strobe && !cpu_write;
            if (rd_pend_q) begin
                rd_q <= cpu_rddata;
            end
        end
    end

    // Master address and data only matter with the strobe
    always_ff @(posedge clk) begin
        if (acc_go) begin
            cpu_addr   <= ptr_addr_q[acc_port];
            cpu_wrdata <= wdata_p[2];
        end
    end

endmodule

`default_nettype wire

// File: hw/vbus_pkg.sv
`default_nettype none

`include "vbus_defines.svh"

package vbus_pkg;

    // VRAM byte address
    typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

    // Data byte on host bus and VRAM
    typedef logic [7:0] byte_t;

    // Pointer auto-increment
    typedef logic [3:0] addr_incr_t;

    // Host register index
    typedef logic [2:0] reg_idx_t;

    // One bit per interrupt source
    typedef logic [`IRQ_W-1:0] irq_vec_t;

    // Line fetcher
    typedef enum logic [0:0] {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_t;

endpackage

`default_nettype wire

// File: hw/vbus_defines.svh
`ifndef VBUS_DEFINES_SVH
`define VBUS_DEFINES_SVH

// VRAM byte address width as seen by the host
`define VRAM_ADDR_W 19

// Address bits actually backed by RAM, upper bits alias
`define VRAM_DEPTH_LOG2 12

// phi2 divider width
// MSB of the divider is phi2, so the bus period is 2**W clk
`define EXTBUS_CLKDIV_W 4

// Interrupt sources
`define IRQ_W 8

`endif
